// ==== Makefile ====
# Verilator simulation of the banked APB memory

VERILATOR ?= verilator
TOP ?= banked_mem_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= TEST PASS
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+include
source/mem_types_pkg.sv
source/apb_pkg.sv
source/ram_single_port.sv
source/apb_bank_router.sv
source/bank_read_collect.sv
source/banked_mem_top.sv
tests/banked_mem_checker.sv
tests/banked_mem_properties.sv
tests/banked_mem_tb.sv

// ==== include/banked_mem_settings.svh ====
`ifndef BANKED_MEM_SETTINGS_SVH
`define BANKED_MEM_SETTINGS_SVH

// Consecutive word addresses rotate over the banks
`define MEM_NUM_BANKS 4
`define MEM_BANK_ADDR_WIDTH 8 // Words per bank is two to this power

`define MEM_DATA_WIDTH 32
`define MEM_BYTE_WIDTH 8

// Cycles from the first access cycle of a read to its data
`define MEM_READ_LATENCY 2

`define APB_ADDR_WIDTH 16 // Byte address seen on the bus

`endif

// ==== source/apb_bank_router.sv ====
`timescale 1ns/100ps

module apb_bank_router (
	input logic clk,
	input logic rst_n,
	input apb_pkg::apb_req_t apb,
	output mem_types_pkg::bank_req_t bank_req,
	output mem_types_pkg::read_tag_t read_tag,
	output logic done,
	output logic err
);
	import apb_pkg::*;
	import mem_types_pkg::*;

	localparam int ADDR_BITS = $bits(apb_addr_t);
	localparam int BYTE_SHIFT = $clog2(BYTES_PER_WORD);
	localparam int WORD_ADDR_BITS = ADDR_BITS - BYTE_SHIFT;

	// Bits below this position address implemented storage
	localparam int USED_BITS = BYTE_SHIFT + BANK_SEL_WIDTH + $bits(bank_addr_t);

	logic issued;
	logic first_access;
	logic in_range;
	logic [WORD_ADDR_BITS-1:0] word_addr;

	assign word_addr = apb.paddr[ADDR_BITS-1:BYTE_SHIFT];
	assign in_range = (apb.paddr >> USED_BITS) == '0;

	// Only one access cycle per transfer issues to a bank
	assign first_access = apb.psel && apb.penable && !issued;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issued <= 1'b0;
		end else if (!apb.penable) begin
			issued <= 1'b0; // Setup phase or idle
		end else if (first_access) begin
			issued <= 1'b1;
		end
	end

	always_comb begin
		bank_req = '0;
		bank_req.bank = word_addr[BANK_SEL_WIDTH-1:0];
		bank_req.addr = word_addr[BANK_SEL_WIDTH +: $bits(bank_addr_t)];
		bank_req.wdata.word = apb.pwdata;
		bank_req.en = first_access && in_range;

		// A read still enables the bank, but with no lane strobed
		if (apb.pwrite) begin
			bank_req.strobe = apb.pstrb;
		end else begin
			bank_req.strobe = '0;
		end
	end

	always_comb begin
		read_tag.valid = first_access && in_range && !apb.pwrite;
		read_tag.bank = bank_req.bank;
	end

	// Writes and range errors are answered in the first access cycle
	assign done = first_access && (apb.pwrite || !in_range);
	assign err = first_access && !in_range;

endmodule

// ==== source/apb_pkg.sv ====
`include "banked_mem_settings.svh"

package apb_pkg;
	typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [`MEM_DATA_WIDTH-1:0] apb_data_t;
	typedef logic [`MEM_DATA_WIDTH/8-1:0] apb_strb_t; // One bit per 8-bit byte

	// Master side of the bus
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
		apb_strb_t pstrb;
	} apb_req_t;

	// Slave side of the bus
	typedef struct packed {
		logic pready;
		apb_data_t prdata;
		logic pslverr;
	} apb_rsp_t;
endpackage

// ==== source/bank_read_collect.sv ====
`timescale 1ns/100ps

`include "banked_mem_settings.svh"

module bank_read_collect (
	input logic clk,
	input logic rst_n,
	input mem_types_pkg::read_tag_t read_tag,
	input logic done,
	input logic err,
	input mem_types_pkg::word_t bank_rdata [`MEM_NUM_BANKS],
	output apb_pkg::apb_rsp_t apb_rsp
);
	import mem_types_pkg::*;

	localparam int LATENCY = `MEM_READ_LATENCY;

	read_tag_t out_tag; // Tag whose bank data is valid this cycle

	generate
		if (LATENCY == 0) begin : g_no_delay
			assign out_tag = read_tag;
		end else begin : g_tag_pipe
			// One stage per register in the bank read path
			read_tag_t tag_pipe [LATENCY];

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					for (int i = 0; i < LATENCY; i++) begin
						tag_pipe[i] <= '0;
					end
				end else begin
					tag_pipe[0] <= read_tag;
					for (int i = 1; i < LATENCY; i++) begin
						tag_pipe[i] <= tag_pipe[i-1];
					end
				end
			end

			assign out_tag = tag_pipe[LATENCY-1];
		end
	endgenerate

	// Only one transfer is ever in flight, so done and out_tag never meet
	always_comb begin
		apb_rsp.pready = out_tag.valid || done;
		apb_rsp.pslverr = done && err;

		if (out_tag.valid) begin
			apb_rsp.prdata = bank_rdata[out_tag.bank];
		end else begin
			apb_rsp.prdata = '0; // Writes and errors return zero
		end
	end

endmodule

// ==== source/banked_mem_top.sv ====
`timescale 1ns/100ps

`include "banked_mem_settings.svh"

module banked_mem_top (
	input logic clk,
	input logic rst_n,
	input apb_pkg::apb_req_t apb,
	output apb_pkg::apb_rsp_t apb_rsp
);
	import mem_types_pkg::*;

	bank_req_t bank_req;
	read_tag_t read_tag;
	logic done;
	logic err;
	logic [`MEM_NUM_BANKS-1:0] bank_en; // One enable per bank
	word_t bank_rdata [`MEM_NUM_BANKS];

	apb_bank_router i_apb_bank_router (
		.clk(clk),
		.rst_n(rst_n),
		.apb(apb),
		.bank_req(bank_req),
		.read_tag(read_tag),
		.done(done),
		.err(err)
	);

	generate
		for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
			// Every bank sees the same request, only the selected one is enabled
			assign bank_en[i] = bank_req.en && (bank_req.bank == bank_sel_t'(i));

			ram_single_port #(
				.ADDR_WIDTH(`MEM_BANK_ADDR_WIDTH),
				.DATA_WIDTH(`MEM_DATA_WIDTH),
				.BYTE_WIDTH(`MEM_BYTE_WIDTH),
				.READ_LATENCY(`MEM_READ_LATENCY)
			) i_ram_single_port (
				.clk(clk),
				.en(bank_en[i]),
				.addr(bank_req.addr),
				.strobe(bank_req.strobe),
				.wdata(bank_req.wdata),
				.rdata(bank_rdata[i])
			);
		end
	endgenerate

	bank_read_collect i_bank_read_collect (
		.clk(clk),
		.rst_n(rst_n),
		.read_tag(read_tag),
		.done(done),
		.err(err),
		.bank_rdata(bank_rdata),
		.apb_rsp(apb_rsp)
	);

endmodule

// ==== source/mem_types_pkg.sv ====
`include "banked_mem_settings.svh"

package mem_types_pkg;
	localparam int BANK_SEL_WIDTH = $clog2(`MEM_NUM_BANKS);
	localparam int BYTES_PER_WORD = `MEM_DATA_WIDTH / `MEM_BYTE_WIDTH;

	typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;
	typedef logic [`MEM_BANK_ADDR_WIDTH-1:0] bank_addr_t;
	typedef logic [BYTES_PER_WORD-1:0] strobe_t;
	typedef logic [`MEM_DATA_WIDTH-1:0] word_t;
	typedef logic [BYTES_PER_WORD-1:0][`MEM_BYTE_WIDTH-1:0] lanes_t;

	// Same bits seen as a word or as byte lanes
	typedef union packed {
		word_t word;
		lanes_t lanes;
	} word_view_t;

	typedef struct packed {
		logic en;
		bank_sel_t bank;
		bank_addr_t addr; // Word address inside the bank
		strobe_t strobe;
		word_view_t wdata;
	} bank_req_t;

	typedef struct packed {
		logic valid;
		bank_sel_t bank;
	} read_tag_t;
endpackage

// ==== source/ram_single_port.sv ====
`timescale 1ns/100ps

module ram_single_port #(
	parameter int ADDR_WIDTH = 8,
	parameter int DATA_WIDTH = 32,
	parameter int BYTE_WIDTH = 8,
	parameter int READ_LATENCY = 1,
	localparam int NUM_WORDS = 2 ** ADDR_WIDTH,
	localparam int LANES = DATA_WIDTH / BYTE_WIDTH,
	localparam type addr_t = logic [ADDR_WIDTH-1:0],
	localparam type strobe_t = logic [LANES-1:0],
	localparam type word_t = logic [DATA_WIDTH-1:0],
	localparam type view_t = union packed {
		word_t word;
		logic [LANES-1:0][BYTE_WIDTH-1:0] lanes;
	}
) (
	input logic clk,
	input logic en,
	input addr_t addr,
	input strobe_t strobe,
	input view_t wdata,
	output word_t rdata
);
	view_t mem [NUM_WORDS];

	// Contents start out as zero
	initial begin
		for (int i = 0; i < NUM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	generate
		if (READ_LATENCY == 0) begin : g_comb_read
			assign rdata = mem[addr].word;
		end else begin : g_reg_read
			word_t stage [READ_LATENCY];

			always_ff @(posedge clk) begin
				stage[0] <= mem[addr].word; // Old contents on a write cycle
				for (int i = 1; i < READ_LATENCY; i++) begin
					stage[i] <= stage[i-1];
				end
			end

			assign rdata = stage[READ_LATENCY-1];
		end
	endgenerate

	always @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < LANES; i++) begin
				if (strobe[i]) begin
					mem[addr].lanes[i] <= wdata.lanes[i]; // Unstrobed lanes keep their value
				end
			end
		end
	end

endmodule

// ==== tests/banked_mem_checker.sv ====
`timescale 1ns/100ps

`include "banked_mem_settings.svh"

module banked_mem_checker #(
	parameter int NAME_CHARS = 24
) (
	input logic clk,
	input logic rst_n,
	input apb_pkg::apb_req_t apb,
	input apb_pkg::apb_rsp_t apb_rsp,
	input logic [8*NAME_CHARS-1:0] exp_name,
	input apb_pkg::apb_data_t exp_prdata,
	input logic exp_pslverr,
	output int pass_count,
	output int fail_count
);
	import apb_pkg::*;

	// Byte address bits that reach storage
	localparam int USED_BITS = 2 + $clog2(`MEM_NUM_BANKS) + `MEM_BANK_ADDR_WIDTH;
	localparam int NUM_BYTES = 2 ** USED_BITS;
	localparam int LANES = $bits(apb_strb_t);

	typedef logic [USED_BITS-1:0] byte_addr_t;

	bit [7:0] ref_mem [NUM_BYTES]; // Two-state so it starts at zero like the banks

	function automatic apb_data_t read_reference(input byte_addr_t base);
		apb_data_t word;
		for (int lane = 0; lane < LANES; lane++) begin
			word[lane*8 +: 8] = ref_mem[base + byte_addr_t'(lane)];
		end
		return word;
	endfunction

	task automatic check_transfer();
		byte_addr_t base;
		logic in_range;
		apb_data_t want_data;
		logic want_err;
		in_range = (apb.paddr >> USED_BITS) == '0;
		base = byte_addr_t'(apb.paddr) & ~byte_addr_t'(LANES - 1);
		want_err = !in_range;
		want_data = '0;
		if (in_range && !apb.pwrite) begin
			want_data = read_reference(base);
		end
		if (exp_prdata !== want_data || exp_pslverr !== want_err) begin
			$display("Fail %0s table expects %h/%b but the reference memory gives %h/%b",
				exp_name, exp_prdata, exp_pslverr, want_data, want_err);
			fail_count++;
		end else if (apb_rsp.prdata !== want_data) begin
			$display("Fail %0s expected %h actual %h", exp_name, want_data, apb_rsp.prdata);
			fail_count++;
		end else if (apb_rsp.pslverr !== want_err) begin
			$display("Fail %0s expected pslverr %b actual pslverr %b",
				exp_name, want_err, apb_rsp.pslverr);
			fail_count++;
		end else begin
			$display("Pass %0s prdata %h pslverr %b", exp_name, apb_rsp.prdata, apb_rsp.pslverr);
			pass_count++;
		end
		// Range errors never reach a bank
		if (in_range && apb.pwrite) begin
			for (int lane = 0; lane < LANES; lane++) begin
				if (apb.pstrb[lane]) begin
					ref_mem[base + byte_addr_t'(lane)] = apb.pwdata[lane*8 +: 8];
				end
			end
		end
	endtask

	// The transfer completes at the next rising edge when pready is high here
	always @(negedge clk) begin
		if (rst_n && apb.psel && apb.penable && apb_rsp.pready) begin
			check_transfer();
		end
	end

endmodule

// ==== tests/banked_mem_properties.sv ====
`timescale 1ns/100ps

`include "banked_mem_settings.svh"

module banked_mem_properties (
	input logic clk,
	input logic rst_n,
	input apb_pkg::apb_req_t apb,
	input apb_pkg::apb_rsp_t apb_rsp,
	input logic [`MEM_NUM_BANKS-1:0] bank_en
);
	import mem_types_pkg::*;

	localparam int LATENCY = `MEM_READ_LATENCY;
	localparam int USED_BITS = 2 + BANK_SEL_WIDTH + `MEM_BANK_ADDR_WIDTH;

	logic prev_penable;
	logic access;
	logic in_range;
	logic read_start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_penable <= 1'b0;
		end else begin
			prev_penable <= apb.penable;
		end
	end

	assign access = apb.psel && apb.penable;
	assign in_range = (apb.paddr >> USED_BITS) == '0;
	assign read_start = access && !prev_penable && !apb.pwrite && in_range; // First access cycle

	ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		apb_rsp.pready |-> access)
		else $error("pready seen outside the access phase");

	read_ready_on_time: assert property (@(posedge clk) disable iff (!rst_n)
		read_start |-> ##LATENCY apb_rsp.pready)
		else $error("Read pready missing after the bank latency");

	read_ready_not_early: assert property (@(posedge clk) disable iff (!rst_n)
		apb_rsp.pready && !apb.pwrite && in_range |-> $past(read_start, LATENCY))
		else $error("Read pready without a read start one latency earlier");

	one_bank_enabled: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(bank_en))
		else $error("More than one bank enabled in a cycle");

endmodule

bind banked_mem_top banked_mem_properties i_banked_mem_properties (
	.clk(clk),
	.rst_n(rst_n),
	.apb(apb),
	.apb_rsp(apb_rsp),
	.bank_en(bank_en)
);

// ==== tests/banked_mem_tb.sv ====
`timescale 1ns/100ps

`include "banked_mem_settings.svh"

module banked_mem_tb;
	import apb_pkg::*;

	localparam int NAME_CHARS = 24;
	localparam int RANDOM_PAIRS = 12;
	localparam int USED_BITS = 2 + $clog2(`MEM_NUM_BANKS) + `MEM_BANK_ADDR_WIDTH;
	localparam int RANGE_BYTES = 2 ** USED_BITS;

	typedef logic [8*NAME_CHARS-1:0] name_t;

	typedef struct packed {
		name_t name;
		logic pwrite;
		apb_addr_t paddr;
		apb_strb_t pstrb;
		apb_data_t pwdata;
		apb_data_t exp_prdata;
		logic exp_pslverr;
	} test_t;

	logic clk = 1'b0;
	logic rst_n;
	apb_req_t apb;
	apb_rsp_t apb_rsp;
	name_t exp_name;
	apb_data_t exp_prdata;
	logic exp_pslverr;
	int pass_count;
	int fail_count;
	int cycle_count;
	int cycle_limit;
	logic [31:0] lcg_state;
	test_t tests[$];

	always #50 clk = ~clk;

	banked_mem_top i_banked_mem_top (
		.clk(clk),
		.rst_n(rst_n),
		.apb(apb),
		.apb_rsp(apb_rsp)
	);

	banked_mem_checker #(
		.NAME_CHARS(NAME_CHARS)
	) i_banked_mem_checker (
		.clk(clk),
		.rst_n(rst_n),
		.apb(apb),
		.apb_rsp(apb_rsp),
		.exp_name(exp_name),
		.exp_prdata(exp_prdata),
		.exp_pslverr(exp_pslverr),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, a transfer never got pready", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic name_t numbered_name(input logic [8*7-1:0] prefix, input int n);
		return name_t'({prefix, 8'h30 + 8'(n / 10), 8'h30 + 8'(n % 10)});
	endfunction

	function automatic void add_test(input name_t name, input logic pwrite,
			input apb_addr_t paddr, input apb_strb_t pstrb, input apb_data_t pwdata,
			input apb_data_t want_prdata, input logic want_pslverr);
		test_t t;
		t.name = name;
		t.pwrite = pwrite;
		t.paddr = paddr;
		t.pstrb = pstrb;
		t.pwdata = pwdata;
		t.exp_prdata = want_prdata;
		t.exp_pslverr = want_pslverr;
		tests.push_back(t);
	endfunction

	task automatic build_table();
		apb_addr_t addr;
		apb_data_t data;
		// Nothing written yet so the banks read as zero
		add_test("rd_init_low", 1'b0, 16'h0000, 4'h0, 32'h0, 32'h0, 1'b0);
		add_test("rd_init_top", 1'b0, 16'h0ffc, 4'h0, 32'h0, 32'h0, 1'b0);
		add_test("wr_full", 1'b1, 16'h0010, 4'hf, 32'hcafe_f00d, 32'h0, 1'b0);
		add_test("rd_full", 1'b0, 16'h0010, 4'h0, 32'h0, 32'hcafe_f00d, 1'b0);
		add_test("wr_lane0", 1'b1, 16'h0010, 4'h1, 32'h1122_3344, 32'h0, 1'b0);
		add_test("wr_lane3_lane1", 1'b1, 16'h0010, 4'ha, 32'h5566_7788, 32'h0, 1'b0);
		add_test("rd_partial", 1'b0, 16'h0010, 4'h0, 32'h0, 32'h55fe_7744, 1'b0);
		// One word in each bank
		add_test("wr_bank0", 1'b1, 16'h0100, 4'hf, 32'h1000_0001, 32'h0, 1'b0);
		add_test("wr_bank1", 1'b1, 16'h0104, 4'hf, 32'h2000_0002, 32'h0, 1'b0);
		add_test("wr_bank2", 1'b1, 16'h0108, 4'hf, 32'h3000_0003, 32'h0, 1'b0);
		add_test("wr_bank3", 1'b1, 16'h010c, 4'hf, 32'h4000_0004, 32'h0, 1'b0);
		add_test("rd_bank3", 1'b0, 16'h010c, 4'h0, 32'h0, 32'h4000_0004, 1'b0);
		add_test("rd_bank2", 1'b0, 16'h0108, 4'h0, 32'h0, 32'h3000_0003, 1'b0);
		add_test("rd_bank1", 1'b0, 16'h0104, 4'h0, 32'h0, 32'h2000_0002, 1'b0);
		add_test("rd_bank0", 1'b0, 16'h0100, 4'h0, 32'h0, 32'h1000_0001, 1'b0);
		add_test("wr_out_of_range", 1'b1, 16'h1100, 4'hf, 32'hdead_beef, 32'h0, 1'b1);
		add_test("rd_out_of_range", 1'b0, 16'h8010, 4'h0, 32'h0, 32'h0, 1'b1);
		add_test("rd_alias", 1'b0, 16'h0100, 4'h0, 32'h0, 32'h1000_0001, 1'b0); // Alias of 0x1100
		for (int i = 0; i < RANDOM_PAIRS; i++) begin
			addr = apb_addr_t'(next_random() % RANGE_BYTES);
			addr[1:0] = 2'b00;
			data = next_random();
			add_test(numbered_name("rnd_wr_", i), 1'b1, addr, 4'hf, data, 32'h0, 1'b0);
			add_test(numbered_name("rnd_rd_", i), 1'b0, addr, 4'h0, 32'h0, data, 1'b0);
		end
	endtask

	task automatic run_transfer(input test_t t);
		@(posedge clk);
		#1;
		exp_name = t.name;
		exp_prdata = t.exp_prdata;
		exp_pslverr = t.exp_pslverr;
		apb.psel = 1'b1; // Setup phase
		apb.penable = 1'b0;
		apb.pwrite = t.pwrite;
		apb.paddr = t.paddr;
		apb.pstrb = t.pstrb;
		apb.pwdata = t.pwdata;
		@(posedge clk);
		#1;
		apb.penable = 1'b1;
		do begin
			@(negedge clk);
		end while (!apb_rsp.pready);
		@(posedge clk);
		#1;
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		apb = '0;
		exp_name = '0;
		exp_prdata = '0;
		exp_pslverr = 1'b0;
		lcg_state = 32'he365_cf0c;
		build_table();
		cycle_limit = tests.size() * (`MEM_READ_LATENCY + 3) + 50;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (tests[i]) begin
			run_transfer(tests[i]);
		end
		repeat (2) @(posedge clk);
		$display("Tests %0d, passed %0d, failed %0d", tests.size(), pass_count, fail_count);
		if (pass_count + fail_count != tests.size()) begin
			$display("The checker saw %0d results for %0d transfers",
				pass_count + fail_count, tests.size());
		end
		if (fail_count == 0 && pass_count == tests.size()) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
